/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

   localparam int WORD_W    = 16;
   localparam int REG_IDX_W = 3;
   localparam int NUM_REGS  = 8;
   localparam int IMM_W     = 8;  // d field in bits 7..0
   localparam int SHAMT_W   = 4;  // Shift amount in bits 3..0

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   typedef enum logic [1:0] {
      op_ld  = 2'd0,
      op_st  = 2'd1,
      op_imm = 2'd2,
      op_alu = 2'd3
   } opcode_e;

   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_and  = 4'd2,
      alu_or   = 4'd3,
      alu_xor  = 4'd4,
      alu_cmp  = 4'd5,
      alu_mov  = 4'd6,
      alu_sll  = 4'd8,
      alu_slr  = 4'd9,   // Rotate left
      alu_srl  = 4'd10,
      alu_sra  = 4'd11,
      alu_none = 4'd15   // Passes B
   } alu_op_e;

   typedef enum logic [2:0] {
      jmp_none   = 3'd0,
      jmp_always = 3'd1,
      jmp_eq     = 3'd2,
      jmp_lt     = 3'd3,
      jmp_le     = 3'd4,
      jmp_ne     = 3'd5
   } jump_e;

   typedef enum logic [1:0] {
      src_a_reg_b = 2'd0,
      src_a_pc    = 2'd1,
      src_a_zero  = 2'd2
   } src_a_e;

   typedef enum logic [1:0] {
      src_b_reg_a = 2'd0,
      src_b_shift = 2'd1,
      src_b_imm   = 2'd2,
      src_b_zero  = 2'd3
   } src_b_e;

   typedef enum logic [1:0] {
      wb_alu  = 2'd0,
      wb_mem  = 2'd1,
      wb_link = 2'd2,
      wb_imm  = 2'd3
   } wb_sel_e;

endpackage

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

package core_pkg;
   import isa_pkg::*;

   typedef struct packed {
      jump_e   jump;
      alu_op_e alu_op;
      src_a_e  src_a;
      src_b_e  src_b;
      wb_sel_e wb_sel;
      logic    reg_write;
      logic    write_to_ra;  // Only LD targets ra
      logic    mem_read;
      logic    mem_write;
      logic    out_en;
      logic    is_halt;
      logic    set_flags;
   } ctrl_t;

   localparam ctrl_t CTRL_NOP = '{
      jump:    jmp_none,
      alu_op:  alu_none,
      src_a:   src_a_reg_b,
      src_b:   src_b_reg_a,
      wb_sel:  wb_alu,
      default: 1'b0
   };

   typedef struct packed {
      logic               valid;
      ctrl_t              ctrl;
      reg_idx_t           ra;
      reg_idx_t           rb;
      word_t              ra_val;
      word_t              rb_val;
      word_t              imm;       // Sign-extended d
      logic [SHAMT_W-1:0] shamt;
      word_t              pc_plus1;
   } id_ex_t;

   typedef struct packed {
      logic z;
      logic s;
      logic v;
      logic c;
   } flags_t;

endpackage

`default_nettype wire

/* controller.sv */
`timescale 1ns/1ps
`default_nettype none

module controller
   import isa_pkg::*, core_pkg::*;
(
   input  logic     flushed,
   input  word_t    inst_id,
   output ctrl_t    ctrl,
   output reg_idx_t ra,
   output reg_idx_t rb
);

   opcode_e    op;
   logic [3:0] ty;

   assign op = opcode_e'(inst_id[15:14]);
   assign ra = inst_id[13:11];
   assign rb = inst_id[10:8];
   assign ty = inst_id[7:4];

   always_comb begin
      ctrl = CTRL_NOP;

      if (!flushed) begin
         case (op)
            op_ld: begin  // ra = mem[rb + d]
               ctrl.reg_write   = 1'b1;
               ctrl.write_to_ra = 1'b1;
               ctrl.src_b       = src_b_imm;
               ctrl.mem_read    = 1'b1;
               ctrl.wb_sel      = wb_mem;
            end
            op_st: begin
               ctrl.mem_write = 1'b1;
               ctrl.src_b     = src_b_imm;
            end
            op_imm: begin
               case (ra)
                  3'd0: begin  // LI
                     ctrl.reg_write = 1'b1;
                     ctrl.wb_sel    = wb_imm;
                  end
                  3'd1: begin  // ADDI
                     ctrl.reg_write = 1'b1;
                     ctrl.alu_op    = alu_add;
                     ctrl.src_b     = src_b_imm;
                  end
                  3'd2: begin  // CMPI
                     ctrl.alu_op    = alu_cmp;
                     ctrl.src_b     = src_b_imm;
                     ctrl.set_flags = 1'b1;
                  end
                  3'd4: begin  // B
                     ctrl.jump   = jmp_always;
                     ctrl.alu_op = alu_add;
                     ctrl.src_a  = src_a_pc;
                     ctrl.src_b  = src_b_imm;
                  end
                  3'd5: begin  // BAL
                     ctrl.jump      = jmp_always;
                     ctrl.alu_op    = alu_add;
                     ctrl.src_a     = src_a_pc;
                     ctrl.src_b     = src_b_imm;
                     ctrl.reg_write = 1'b1;
                     ctrl.wb_sel    = wb_link;
                  end
                  3'd6: begin  // BR to rb + d
                     ctrl.jump   = jmp_always;
                     ctrl.alu_op = alu_add;
                     ctrl.src_b  = src_b_imm;
                  end
                  3'd7: begin
                     case (rb)
                        3'd0:    ctrl.jump = jmp_eq;   // BE
                        3'd1:    ctrl.jump = jmp_lt;   // BLT
                        3'd2:    ctrl.jump = jmp_le;   // BLE
                        3'd3:    ctrl.jump = jmp_ne;   // BNE
                        default: ctrl.jump = jmp_none;
                     endcase
                     if (ctrl.jump != jmp_none) begin
                        ctrl.alu_op = alu_add;
                        ctrl.src_a  = src_a_pc;
                        ctrl.src_b  = src_b_imm;
                     end
                  end
                  default: ;  // LOCK and UNLOCK
               endcase
            end
            op_alu: begin
               case (ty)
                  alu_add, alu_sub, alu_and, alu_or, alu_xor: begin
                     ctrl.alu_op    = alu_op_e'(ty);
                     ctrl.reg_write = 1'b1;
                     ctrl.set_flags = 1'b1;
                  end
                  alu_cmp: begin
                     ctrl.alu_op    = alu_cmp;
                     ctrl.set_flags = 1'b1;
                  end
                  alu_mov: begin
                     ctrl.alu_op    = alu_mov;
                     ctrl.src_a     = src_a_zero;
                     ctrl.reg_write = 1'b1;
                     ctrl.set_flags = 1'b1;
                  end
                  alu_sll, alu_slr, alu_srl, alu_sra: begin
                     ctrl.alu_op    = alu_op_e'(ty);
                     ctrl.src_b     = src_b_shift;
                     ctrl.reg_write = 1'b1;
                     ctrl.set_flags = 1'b1;
                  end
                  4'd13: ctrl.out_en  = 1'b1;  // OUT
                  4'd15: ctrl.is_halt = 1'b1;  // HLT
                  default: ;  // IN and reserved types
               endcase
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
   import isa_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  reg_idx_t raddr_a,
   input  reg_idx_t raddr_b,
   output word_t    rdata_a,
   output word_t    rdata_b,
   input  logic     we,
   input  reg_idx_t waddr,
   input  word_t    wdata
);

   word_t regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[waddr] <= wdata;
      end
   end

   // Same-cycle write is forwarded to the readers
   assign rdata_a = (we && waddr == raddr_a) ? wdata : regs[raddr_a];
   assign rdata_b = (we && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
   import isa_pkg::*;
#(
   parameter int IMEM_DEPTH = 256
) (
   input  logic  clk,
   input  logic  reset,
   input  logic  halt,
   input  logic  imem_we,
   input  word_t imem_addr,
   input  word_t imem_data,
   input  logic  branch_taken,
   input  word_t branch_target,
   output word_t inst_id,
   output word_t pc_plus1_id,
   output logic  valid_id
);

   localparam int IMEM_AW = $clog2(IMEM_DEPTH);

   word_t imem [IMEM_DEPTH];
   word_t pc;
   word_t pc_plus1;

   assign pc_plus1 = pc + 16'd1;

   always_ff @(posedge clk) begin
      if (imem_we) begin  // Program load port
         imem[imem_addr[IMEM_AW-1:0]] <= imem_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc       <= '0;
         valid_id <= 1'b0;
      end else if (branch_taken) begin
         pc       <= branch_target;
         valid_id <= 1'b0;  // Drops the fetch in flight
      end else if (halt) begin
         valid_id <= 1'b0;  // PC holds
      end else begin
         pc       <= pc_plus1;
         valid_id <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      inst_id     <= imem[pc[IMEM_AW-1:0]];
      pc_plus1_id <= pc_plus1;
   end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
   import isa_pkg::*, core_pkg::*;
(
   input  alu_op_e op,
   input  word_t   a,
   input  word_t   b,
   output word_t   result,
   output flags_t  flags
);

   logic [WORD_W:0]     sum;     // Carry in the top bit
   logic [2*WORD_W-1:0] rot;
   logic [SHAMT_W-1:0]  amount;

   assign amount = b[SHAMT_W-1:0];
   assign rot    = {a, a} << amount;

   always_comb begin
      sum     = '0;
      result  = b;
      flags.c = 1'b0;
      flags.v = 1'b0;

      case (op)
         alu_add: begin
            sum     = {1'b0, a} + {1'b0, b};
            result  = sum[WORD_W-1:0];
            flags.c = sum[WORD_W];
            flags.v = (a[WORD_W-1] == b[WORD_W-1]) && (result[WORD_W-1] != a[WORD_W-1]);
         end
         alu_sub, alu_cmp: begin  // a + ~b + 1
            sum     = {1'b0, a} + {1'b0, ~b} + 17'd1;
            result  = sum[WORD_W-1:0];
            flags.c = sum[WORD_W];
            flags.v = (a[WORD_W-1] != b[WORD_W-1]) && (result[WORD_W-1] != a[WORD_W-1]);
         end
         alu_and: result = a & b;
         alu_or:  result = a | b;
         alu_xor: result = a ^ b;
         alu_sll: result = a << amount;
         alu_slr: result = rot[2*WORD_W-1:WORD_W];
         alu_srl: result = a >> amount;
         alu_sra: result = word_t'($signed(a) >>> amount);
         default: result = b;  // mov and none
      endcase

      flags.z = (result == '0);
      flags.s = result[WORD_W-1];
   end

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
   import isa_pkg::*, core_pkg::*;
#(
   parameter int DMEM_DEPTH = 256
) (
   input  logic     clk,
   input  logic     reset,
   input  id_ex_t   ex,
   output logic     rf_we,
   output reg_idx_t rf_waddr,
   output word_t    rf_wdata,
   output logic     branch_taken,
   output word_t    branch_target,
   output logic     out_valid,
   output word_t    out_data,
   output logic     halted
);

   localparam int DMEM_AW = $clog2(DMEM_DEPTH);

   word_t  dmem [DMEM_DEPTH];
   word_t  op_a;
   word_t  op_b;
   word_t  alu_result;
   word_t  mem_addr;
   word_t  mem_rdata;
   flags_t alu_flags;
   flags_t flags_q;
   logic   cond;

   always_comb begin
      case (ex.ctrl.src_a)
         src_a_pc:   op_a = ex.pc_plus1;
         src_a_zero: op_a = '0;
         default:    op_a = ex.rb_val;
      endcase
      case (ex.ctrl.src_b)
         src_b_shift: op_b = word_t'(ex.shamt);
         src_b_imm:   op_b = ex.imm;
         src_b_zero:  op_b = '0;
         default:     op_b = ex.ra_val;
      endcase
   end

   alu u_alu (
      .op     (ex.ctrl.alu_op),
      .a      (op_a),
      .b      (op_b),
      .result (alu_result),
      .flags  (alu_flags)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         flags_q <= '0;
      end else if (ex.valid && ex.ctrl.set_flags) begin
         flags_q <= alu_flags;
      end
   end

   // Signed conditions from the last flag-setting instruction
   always_comb begin
      case (ex.ctrl.jump)
         jmp_always: cond = 1'b1;
         jmp_eq:     cond = flags_q.z;
         jmp_lt:     cond = flags_q.s ^ flags_q.v;
         jmp_le:     cond = flags_q.z | (flags_q.s ^ flags_q.v);
         jmp_ne:     cond = ~flags_q.z;
         default:    cond = 1'b0;
      endcase
   end

   assign branch_taken  = ex.valid & cond;
   assign branch_target = alu_result;

   assign mem_addr  = ex.rb_val + ex.imm;
   assign mem_rdata = ex.ctrl.mem_read ? dmem[mem_addr[DMEM_AW-1:0]] : '0;

   always_ff @(posedge clk) begin
      if (ex.valid && ex.ctrl.mem_write) begin
         dmem[mem_addr[DMEM_AW-1:0]] <= ex.ra_val;
      end
   end

   assign rf_we    = ex.valid & ex.ctrl.reg_write;
   assign rf_waddr = ex.ctrl.write_to_ra ? ex.ra : ex.rb;

   always_comb begin
      case (ex.ctrl.wb_sel)
         wb_mem:  rf_wdata = mem_rdata;
         wb_link: rf_wdata = ex.pc_plus1;  // BAL return address
         wb_imm:  rf_wdata = ex.imm;
         default: rf_wdata = alu_result;
      endcase
   end

   assign out_valid = ex.valid & ex.ctrl.out_en;
   assign out_data  = ex.ra_val;

   always_ff @(posedge clk) begin
      if (reset) begin
         halted <= 1'b0;
      end else if (ex.valid && ex.ctrl.is_halt) begin
         halted <= 1'b1;  // Sticky until reset
      end
   end

endmodule

`default_nettype wire

/* simple_core.sv */
`timescale 1ns/1ps
`default_nettype none

module simple_core
   import isa_pkg::*, core_pkg::*;
#(
   parameter int IMEM_DEPTH = 256,
   parameter int DMEM_DEPTH = 256
) (
   input  logic  clk,
   input  logic  reset,
   input  logic  imem_we,
   input  word_t imem_addr,
   input  word_t imem_data,
   output logic  out_valid,
   output word_t out_data,
   output logic  halted
);

   word_t    inst_id;
   word_t    pc_plus1_id;
   logic     valid_id;
   ctrl_t    ctrl;
   reg_idx_t ra;
   reg_idx_t rb;
   word_t    rdata_a;
   word_t    rdata_b;
   logic     rf_we;
   reg_idx_t rf_waddr;
   word_t    rf_wdata;
   logic     branch_taken;
   word_t    branch_target;
   logic     halt;
   id_ex_t   id_ex_d;
   id_ex_t   id_ex_q;

   // Stop as soon as HLT reaches execute
   assign halt = halted | (id_ex_q.valid & id_ex_q.ctrl.is_halt);

   fetch_stage #(
      .IMEM_DEPTH (IMEM_DEPTH)
   ) u_fetch (
      .clk           (clk),
      .reset         (reset),
      .halt          (halt),
      .imem_we       (imem_we),
      .imem_addr     (imem_addr),
      .imem_data     (imem_data),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .inst_id       (inst_id),
      .pc_plus1_id   (pc_plus1_id),
      .valid_id      (valid_id)
   );

   controller u_ctrl (
      .flushed (branch_taken),
      .inst_id (inst_id),
      .ctrl    (ctrl),
      .ra      (ra),
      .rb      (rb)
   );

   register_file u_rf (
      .clk     (clk),
      .reset   (reset),
      .raddr_a (ra),
      .raddr_b (rb),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b),
      .we      (rf_we),
      .waddr   (rf_waddr),
      .wdata   (rf_wdata)
   );

   always_comb begin
      id_ex_d.valid    = valid_id;
      id_ex_d.ctrl     = ctrl;
      id_ex_d.ra       = ra;
      id_ex_d.rb       = rb;
      id_ex_d.ra_val   = rdata_a;
      id_ex_d.rb_val   = rdata_b;
      id_ex_d.imm      = {{(WORD_W-IMM_W){inst_id[IMM_W-1]}}, inst_id[IMM_W-1:0]};
      id_ex_d.shamt    = inst_id[SHAMT_W-1:0];
      id_ex_d.pc_plus1 = pc_plus1_id;
   end

   always_ff @(posedge clk) begin
      if (reset || branch_taken || halt) begin
         id_ex_q <= '0;
      end else begin
         id_ex_q <= id_ex_d;
      end
   end

   execute_stage #(
      .DMEM_DEPTH (DMEM_DEPTH)
   ) u_exec (
      .clk           (clk),
      .reset         (reset),
      .ex            (id_ex_q),
      .rf_we         (rf_we),
      .rf_waddr      (rf_waddr),
      .rf_wdata      (rf_wdata),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .out_valid     (out_valid),
      .out_data      (out_data),
      .halted        (halted)
   );

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD = 8
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

endmodule

`default_nettype wire

/* simple_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module simple_core_tb
   import isa_pkg::*;
();

   localparam int CLK_PERIOD      = 8;
   localparam int N_TESTS         = 6;
   localparam int CYCLES_PER_TEST = 200;
   localparam int HALT_LIMIT      = 400;

   // Immediate group sub-opcodes sit in the ra field
   localparam logic [2:0] IMM_LI    = 3'd0;
   localparam logic [2:0] IMM_ADDI  = 3'd1;
   localparam logic [2:0] IMM_CMPI  = 3'd2;
   localparam logic [2:0] IMM_B     = 3'd4;
   localparam logic [2:0] IMM_BAL   = 3'd5;
   localparam logic [2:0] IMM_BR    = 3'd6;
   localparam logic [2:0] IMM_BCOND = 3'd7;
   localparam logic [3:0] TY_OUT    = 4'd13;
   localparam logic [3:0] TY_HLT    = 4'd15;

   logic  clk;
   logic  reset;
   logic  imem_we;
   word_t imem_addr;
   word_t imem_data;
   logic  out_valid;
   word_t out_data;
   logic  halted;

   integer seed = 32'h79ea673f;
   int     errors = 0;
   int     checks = 0;
   int     tests_run = 0;
   word_t  prog [$];
   word_t  exp_q [$];
   word_t  out_q [$];

   tb_clock #(
      .PERIOD (CLK_PERIOD)
   ) u_clock (
      .clk (clk)
   );

   simple_core #(
      .IMEM_DEPTH (256),
      .DMEM_DEPTH (256)
   ) UUT (
      .clk       (clk),
      .reset     (reset),
      .imem_we   (imem_we),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .out_valid (out_valid),
      .out_data  (out_data),
      .halted    (halted)
   );

   always @(negedge clk) begin
      if (out_valid) begin
         out_q.push_back(out_data);
      end
   end

   function automatic word_t rand_word();
      logic [31:0] r;
      r = $random(seed);
      return r[15:0];
   endfunction

   function automatic word_t assemble(input logic [1:0] op, input reg_idx_t ra,
                                      input reg_idx_t rb, input logic [7:0] low);
      return {op, ra, rb, low};
   endfunction

   function automatic word_t sext8(input logic [7:0] d);
      return {{8{d[7]}}, d};
   endfunction

   function automatic word_t shift_model(input alu_op_e kind, input word_t x,
                                         input logic [3:0] amt);
      word_t fill;
      fill = x[15] ? ~(16'hffff >> amt) : 16'h0000;  // Sign bits for SRA
      case (kind)
         alu_sll: return x << amt;
         alu_slr: return (x << amt) | (x >> (5'd16 - {1'b0, amt}));
         alu_srl: return x >> amt;
         default: return (x >> amt) | fill;
      endcase
   endfunction

   task automatic push_word(input word_t w);
      prog.push_back(w);
   endtask

   // rb = rb op ra
   task automatic reg_reg(input alu_op_e ty, input reg_idx_t ra, input reg_idx_t rb);
      push_word(assemble(2'd3, ra, rb, {ty, 4'h0}));
   endtask

   task automatic shift_by(input alu_op_e ty, input reg_idx_t rb, input logic [3:0] amt);
      push_word(assemble(2'd3, 3'd0, rb, {ty, amt}));
   endtask

   task automatic imm_form(input logic [2:0] sub, input reg_idx_t rb, input logic [7:0] d);
      push_word(assemble(2'd2, sub, rb, d));
   endtask

   task automatic out_reg(input reg_idx_t ra);
      push_word(assemble(2'd3, ra, 3'd0, {TY_OUT, 4'h0}));
   endtask

   task automatic halt_here();
      push_word(assemble(2'd3, 3'd0, 3'd0, {TY_HLT, 4'h0}));
   endtask

   // Full 16-bit constant through scratch r7
   task automatic load_const(input reg_idx_t rd, input word_t value);
      imm_form(IMM_LI, rd, value[15:8]);
      shift_by(alu_sll, rd, 4'd8);
      imm_form(IMM_LI, 3'd7, value[7:0]);
      shift_by(alu_sll, 3'd7, 4'd8);
      shift_by(alu_srl, 3'd7, 4'd8);
      reg_reg(alu_or, 3'd7, rd);
   endtask

   // MOV dst = a, then dst = a op b, then OUT dst
   task automatic apply_binary(input alu_op_e ty, input reg_idx_t a_reg,
                               input reg_idx_t b_reg, input reg_idx_t dst);
      reg_reg(alu_mov, a_reg, dst);
      reg_reg(ty, b_reg, dst);
      out_reg(dst);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic compare_outputs(input string name);
      int n;
      n = (out_q.size() < exp_q.size()) ? out_q.size() : exp_q.size();
      for (int i = 0; i < n; i++) begin
         check_value(name, exp_q[i], out_q[i]);
      end
      if (out_q.size() != exp_q.size()) begin
         errors++;
         $display("ERROR %s: expected %0d outputs but the core gave %0d",
                  name, exp_q.size(), out_q.size());
      end
   endtask

   task automatic run_program(input string name);
      int errs_before;
      int cycles;
      errs_before = errors;
      next_cycle();
      reset = 1'b1;
      repeat (5) next_cycle();
      for (int i = 0; i < prog.size(); i++) begin
         imem_we   = 1'b1;
         imem_addr = i[15:0];
         imem_data = prog[i];
         next_cycle();
      end
      imem_we = 1'b0;
      out_q.delete();
      reset = 1'b0;
      cycles = 0;
      while (!halted && cycles < HALT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         errors++;
         $display("ERROR %s: core did not halt within %0d cycles", name, HALT_LIMIT);
      end
      repeat (6) @(negedge clk);  // Nothing may run after HLT
      check_value(name, 16'd1, {15'd0, halted});
      compare_outputs(name);
      tests_run++;
      $display("%s: %0d outputs, %0d errors", name, out_q.size(), errors - errs_before);
   endtask

   task automatic register_alu();
      word_t      x;
      word_t      y;
      word_t      r;
      logic [7:0] d;
      x = rand_word();
      y = rand_word();
      r = rand_word();
      d = r[7:0];
      prog.delete();
      exp_q.delete();
      load_const(3'd1, x);
      load_const(3'd2, y);
      apply_binary(alu_add, 3'd1, 3'd2, 3'd3);
      exp_q.push_back(x + y);
      apply_binary(alu_sub, 3'd1, 3'd2, 3'd4);
      exp_q.push_back(x - y);
      apply_binary(alu_and, 3'd2, 3'd1, 3'd5);
      exp_q.push_back(y & x);
      apply_binary(alu_or, 3'd1, 3'd2, 3'd6);
      exp_q.push_back(x | y);
      apply_binary(alu_xor, 3'd2, 3'd1, 3'd3);
      exp_q.push_back(y ^ x);
      reg_reg(alu_mov, 3'd1, 3'd6);
      out_reg(3'd6);
      exp_q.push_back(x);
      reg_reg(alu_mov, 3'd2, 3'd4);  // Dependent chain
      reg_reg(alu_add, 3'd4, 3'd4);
      reg_reg(alu_add, 3'd1, 3'd4);
      out_reg(3'd4);
      exp_q.push_back(y + y + x);
      imm_form(IMM_ADDI, 3'd2, d);
      out_reg(3'd2);
      exp_q.push_back(y + sext8(d));
      imm_form(IMM_LI, 3'd5, d);
      out_reg(3'd5);
      exp_q.push_back(sext8(d));
      halt_here();
      run_program("register_alu");
   endtask

   task automatic shifts();
      alu_op_e    kinds [4];
      logic [3:0] amounts [4];
      word_t      x;
      word_t      r;
      x = rand_word();
      r = rand_word();
      kinds[0]   = alu_sll;
      kinds[1]   = alu_slr;
      kinds[2]   = alu_srl;
      kinds[3]   = alu_sra;
      amounts[0] = 4'd1;
      amounts[1] = 4'd7;
      amounts[2] = 4'd15;
      amounts[3] = r[3:0];
      prog.delete();
      exp_q.delete();
      load_const(3'd1, x);
      for (int k = 0; k < 4; k++) begin
         for (int j = 0; j < 4; j++) begin
            reg_reg(alu_mov, 3'd1, 3'd2);
            shift_by(kinds[k], 3'd2, amounts[j]);
            out_reg(3'd2);
            exp_q.push_back(shift_model(kinds[k], x, amounts[j]));
         end
      end
      halt_here();
      run_program("shifts");
   endtask

   task automatic memory_roundtrip();
      word_t      vals [4];
      word_t      r;
      logic [7:0] base;
      int         off;
      int         dst;
      r = rand_word();
      base = r[7:0];
      prog.delete();
      exp_q.delete();
      imm_form(IMM_LI, 3'd1, base);
      for (int i = 0; i < 4; i++) begin
         vals[i] = rand_word();
         off = 3 * i - 4;  // Some offsets negative
         load_const(3'd2, vals[i]);
         push_word(assemble(2'd1, 3'd2, 3'd1, off[7:0]));  // ST r2
      end
      for (int i = 0; i < 4; i++) begin
         off = 3 * i - 4;
         dst = 3 + i;
         push_word(assemble(2'd0, dst[2:0], 3'd1, off[7:0]));  // LD into r3..r6
         out_reg(dst[2:0]);
         exp_q.push_back(vals[i]);
      end
      halt_here();
      run_program("memory");
   endtask

   task automatic cond_branches();
      word_t p;
      word_t q;
      word_t r;
      int    mark;
      logic  taken;
      prog.delete();
      exp_q.delete();
      for (int c = 0; c < 4; c++) begin
         mark = c + 1;
         imm_form(IMM_LI, mark[2:0] + 3'd2, mark[7:0]);  // Markers 1..4 in r3..r6
      end
      for (int k = 0; k < 4; k++) begin
         r = rand_word();
         case (k)
            0: begin
               p = sext8(r[15:8]);
               q = sext8(r[7:0]);
            end
            1: begin
               p = r;
               q = rand_word();
            end
            2: begin
               p = r;
               q = r;
            end
            default: begin
               p = 16'h7fff;  // Subtract overflows
               q = r | 16'h8000;
            end
         endcase
         if (k == 0) begin
            imm_form(IMM_LI, 3'd1, r[15:8]);
            imm_form(IMM_CMPI, 3'd1, r[7:0]);
         end else begin
            load_const(3'd1, p);
            load_const(3'd2, q);
            reg_reg(alu_cmp, 3'd2, 3'd1);  // Flags of p - q
         end
         for (int c = 0; c < 4; c++) begin
            case (c)
               0:       taken = (p == q);
               1:       taken = ($signed(p) < $signed(q));
               2:       taken = ($signed(p) <= $signed(q));
               default: taken = (p != q);
            endcase
            mark = c + 3;
            imm_form(IMM_BCOND, c[2:0], 8'd1);  // Jumps over the marker
            out_reg(mark[2:0]);
            if (!taken) begin
               mark = c + 1;
               exp_q.push_back(mark[15:0]);
            end
         end
      end
      halt_here();
      run_program("cond_branch");
   endtask

   task automatic call_return();
      word_t      r;
      logic [7:0] m;
      r = rand_word();
      m = r[7:0];
      prog.delete();
      exp_q.delete();
      imm_form(IMM_LI, 3'd5, m);
      imm_form(IMM_BAL, 3'd6, 8'd4);  // Call from 1 to 6
      out_reg(3'd5);
      imm_form(IMM_BAL, 3'd6, 8'd2);  // Call from 3 to 6
      out_reg(3'd5);
      halt_here();
      out_reg(3'd6);                  // Subroutine at 6
      imm_form(IMM_BR, 3'd6, 8'd0);
      out_reg(3'd5);                  // Killed by the return
      exp_q.push_back(16'd2);
      exp_q.push_back(sext8(m));
      exp_q.push_back(16'd4);
      exp_q.push_back(sext8(m));
      run_program("bal_br");
   endtask

   task automatic flush_halt();
      prog.delete();
      exp_q.delete();
      imm_form(IMM_LI, 3'd1, 8'h11);
      imm_form(IMM_LI, 3'd2, 8'h22);
      imm_form(IMM_B, 3'd0, 8'd3);     // Jump from 2 to 6
      out_reg(3'd2);
      out_reg(3'd2);
      out_reg(3'd2);
      out_reg(3'd1);
      imm_form(IMM_CMPI, 3'd1, 8'h11);
      imm_form(IMM_BCOND, 3'd0, 8'd2); // BE from 8 to 11
      out_reg(3'd2);
      out_reg(3'd2);
      out_reg(3'd1);
      halt_here();
      out_reg(3'd2);
      out_reg(3'd2);
      exp_q.push_back(16'h0011);
      exp_q.push_back(16'h0011);
      run_program("flush_halt");
   endtask

   initial begin
      #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("ERROR watchdog expired after %0d cycles", N_TESTS * CYCLES_PER_TEST);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      reset     = 1'b1;
      imem_we   = 1'b0;
      imem_addr = '0;
      imem_data = '0;
      register_alu();
      shifts();
      memory_roundtrip();
      cond_branches();
      call_return();
      flush_halt();
      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* simple_core.f */
isa_pkg.sv
core_pkg.sv
controller.sv
register_file.sv
fetch_stage.sv
alu.sv
execute_stage.sv
simple_core.sv
tb_clock.sv
simple_core_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := simple_core_tb
FILELIST  := simple_core.f
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only -Wall --timing
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
